// File: xc_correlator.f
xc_line_pkg.sv
xc_count_pkg.sv
line_scanner.sv
integration_timer.sv
pair_correlator.sv
count_readout.sv
xc_correlator.sv
xc_correlator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator.
# The run fails if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
	-f xc_correlator.f --top-module xc_correlator_tb -o xc_sim \
	> build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/xc_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulator exited with an error"; exit 1; }

cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log \
	&& { echo "Simulation failed"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// File: xc_correlator_tb.sv
`timescale 1ns/10ps

module xc_correlator_tb
	import xc_count_pkg::*;
();

	localparam int NUM_LINES = 4;
	localparam int MUX_LINES = 2;
	localparam int INTEG_FRAMES = 16;
	localparam int NUM_INPUTS = NUM_LINES * MUX_LINES;
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int SCAN_LEN = MUX_LINES + 1;
	// Windows run by all tests, with slack for the first partial one.
	localparam int NUM_WINDOWS = 14;
	localparam longint WATCHDOG_NS =
		NUM_WINDOWS * (INTEG_FRAMES + 8) * SCAN_LEN * 20 + 16 * 20 + 2000;

	// Stimulus modes.
	localparam int MODE_IDLE = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_GATED = 2;
	localparam int MODE_ONES = 3;
	localparam int MODE_ZEROS = 4;

	logic pll_clk, reset, enable, sh_reset, integration_pulse, result_valid;
	logic [NUM_LINES-1:0] line_in;
	logic [MUX_LINES-1:0] mux_out;
	pair_index_t result_pair;
	count_t result_count;

	logic [31:0] lfsr_state, drive_bits;
	int mode, errors, err_mark, tests_run, tests_failed, skip_total, skip_mark, bursts_done;
	logic monitor_on;
	// Model state.
	int slot, frames_in_win, skipped, since_pulse, burst_idx, burst_min, burst_max;
	logic have_pulse, pulse_due;
	logic [NUM_INPUTS-1:0] frame_img;
	int model_cnt [NUM_PAIRS];
	count_t exp_q [$];

	xc_correlator #(.NUM_LINES(NUM_LINES), .MUX_LINES(MUX_LINES),
		.INTEG_FRAMES(INTEG_FRAMES)) dut0 (
		.pll_clk(pll_clk), .reset(reset), .line_in(line_in), .enable(enable),
		.mux_out(mux_out), .sh_reset(sh_reset), .integration_pulse(integration_pulse),
		.result_valid(result_valid), .result_pair(result_pair), .result_count(result_count)
	);

	always #10 pll_clk = ~pll_clk;

	// ----------------------------------------------------------
	// Random source and input driver.
	// ----------------------------------------------------------

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken.
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	always @(posedge pll_clk) begin
		#2;
		line_in = '0;
		enable = 1'b1;
		if (mode == MODE_RANDOM || mode == MODE_GATED) begin
			take_bits(NUM_LINES, drive_bits);
			line_in = drive_bits[NUM_LINES-1:0];
		end
		if (mode == MODE_GATED) begin
			// Low in about one cycle of eight.
			take_bits(3, drive_bits);
			enable = (drive_bits[2:0] != 3'd0);
		end
		if (mode == MODE_ONES) begin
			line_in = '1;
		end
		if (mode == MODE_IDLE) begin
			enable = 1'b0;
		end
	end

	// ----------------------------------------------------------
	// Reference model and cycle checks.
	// ----------------------------------------------------------

	// Adds one frame to the pair counts, i outer, j inner.
	task automatic add_frame(input logic [NUM_INPUTS-1:0] bits);
		int p;
		p = 0;
		for (int i = 0; i < NUM_INPUTS - 1; i++) begin
			for (int j = i + 1; j < NUM_INPUTS; j++) begin
				if (bits[i] && bits[j]) begin
					model_cnt[p]++;
				end
				p++;
			end
		end
	endtask

	always @(negedge pll_clk) begin : monitor
		logic [MUX_LINES-1:0] exp_mux;
		count_t exp_val;
		if (monitor_on) begin
			exp_mux = '0;
			if (slot < MUX_LINES) begin
				exp_mux[slot] = 1'b1;
			end
			assert (mux_out == exp_mux && sh_reset == (slot == MUX_LINES)) else begin
				$display("[ERROR] %0t ns: mux_out %b sh_reset %b, expected %b %b", $time,
					mux_out, sh_reset, exp_mux, slot == MUX_LINES);
				errors++;
			end
			// Store each group while it is selected.
			for (int k = 0; k < MUX_LINES; k++) begin
				if (mux_out[k]) begin
					frame_img[k*NUM_LINES +: NUM_LINES] = line_in;
				end
			end
			since_pulse++;
			assert (integration_pulse == pulse_due) else begin
				$display("[ERROR] %0t ns: integration_pulse %b, expected %b", $time,
					integration_pulse, pulse_due);
				errors++;
			end
			pulse_due = 1'b0;
			// Pulse spacing grows by one frame per skipped frame.
			if (integration_pulse && have_pulse) begin
				assert (since_pulse == (INTEG_FRAMES + skipped) * SCAN_LEN) else begin
					$display("[ERROR] %0t ns: pulse spacing %0d cycles, expected %0d", $time,
						since_pulse, (INTEG_FRAMES + skipped) * SCAN_LEN);
					errors++;
				end
			end
			// Result burst.
			if (burst_idx >= 0) begin
				exp_val = exp_q.pop_front();
				assert (result_valid && result_pair == pair_index_t'(burst_idx)
					&& result_count == exp_val) else begin
					$display("[ERROR] %0t ns: result %b pair %0d count %0d, expected %0d %0d",
						$time, result_valid, result_pair, result_count, burst_idx, exp_val);
					errors++;
				end
				burst_min = (result_count < burst_min) ? result_count : burst_min;
				burst_max = (result_count > burst_max) ? result_count : burst_max;
				burst_idx++;
				if (burst_idx == NUM_PAIRS) begin
					burst_idx = -1;
					bursts_done++;
				end
			end else begin
				assert (!result_valid) else begin
					$display("[ERROR] %0t ns: result_valid high outside a burst", $time);
					errors++;
				end
			end
			if (integration_pulse) begin
				have_pulse = 1'b1;
				since_pulse = 0;
				skipped = 0;
				assert (exp_q.size() >= NUM_PAIRS) else begin
					$display("Window ended at %0t ns before the model closed one", $time);
					errors++;
				end
				burst_idx = 0;
				burst_min = 1 << 16;
				burst_max = 0;
			end
			// Frame end.
			if (sh_reset && enable) begin
				add_frame(frame_img);
				frames_in_win++;
				if (frames_in_win == INTEG_FRAMES) begin
					for (int p = 0; p < NUM_PAIRS; p++) begin
						exp_q.push_back(count_t'(model_cnt[p]));
						model_cnt[p] = 0;
					end
					frames_in_win = 0;
					pulse_due = 1'b1;
				end
			end else if (sh_reset) begin
				skipped++;
				skip_total++;
			end
			slot = (slot == MUX_LINES) ? 0 : slot + 1;
		end
	end

	// ----------------------------------------------------------
	// Test sequence.
	// ----------------------------------------------------------

	task automatic wait_bursts(input int n);
		int target;
		target = bursts_done + n;
		while (bursts_done < target) begin
			@(posedge pll_clk);
		end
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - err_mark;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("Test %0d %-16s %s, %0d errors", tests_run, name, (n == 0) ? "ok" : "FAIL", n);
		err_mark = errors;
	endtask

	initial begin
		pll_clk = 1'b0;
		reset = 1'b1;
		line_in = '0;
		enable = 1'b0;
		mode = MODE_IDLE;
		monitor_on = 1'b0;
		lfsr_state = 32'h6381;
		{errors, err_mark, tests_run, tests_failed, skip_total, bursts_done} = '0;
		{slot, frames_in_win, skipped, since_pulse, burst_min, burst_max} = '0;
		burst_idx = -1;
		{have_pulse, pulse_due} = '0;
		frame_img = '0;
		foreach (model_cnt[p]) begin
			model_cnt[p] = 0;
		end
		// Last pass samples the cycle in which reset falls.
		for (int k = 0; k < 16; k++) begin
			@(posedge pll_clk);
			if (k == 15) begin
				#2 reset = 1'b0;
			end
			@(negedge pll_clk);
			assert (mux_out == '0 && !sh_reset && !integration_pulse && !result_valid) else begin
				$display("[ERROR] %0t ns: outputs active in reset", $time);
				errors++;
			end
		end
		end_test("reset quiet");
		// Monitor starts with the first select cycle.
		@(posedge pll_clk);
		monitor_on = 1'b1;
		mode = MODE_RANDOM;
		repeat (4 * SCAN_LEN) @(posedge pll_clk);
		end_test("scan order");
		wait_bursts(3);
		end_test("coincidence");
		for (int w = 0; w < 2; w++) begin
			wait_bursts(1);
			assert (burst_max <= INTEG_FRAMES) else begin
				$display("[ERROR] %0t ns: count %0d above window length", $time, burst_max);
				errors++;
			end
		end
		end_test("window restart");
		mode = MODE_GATED;
		skip_mark = skip_total;
		wait_bursts(3);
		assert (skip_total > skip_mark) else begin
			$display("Enable gating test ran without any skipped frame");
			errors++;
		end
		end_test("enable gating");
		// First window after a switch is mixed, the second is clean.
		mode = MODE_ONES;
		wait_bursts(2);
		assert (burst_min == INTEG_FRAMES && burst_max == INTEG_FRAMES) else begin
			$display("[ERROR] %0t ns: all-ones counts %0d to %0d", $time, burst_min, burst_max);
			errors++;
		end
		mode = MODE_ZEROS;
		wait_bursts(2);
		assert (burst_max == 0) else begin
			$display("[ERROR] %0t ns: all-zeros count up to %0d", $time, burst_max);
			errors++;
		end
		end_test("extremes");
		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Ends a stuck run.
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: xc_correlator.sv
`timescale 1ns/10ps

module xc_correlator
	import xc_line_pkg::*;
	import xc_count_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MUX_LINES = 2,
	parameter int INTEG_FRAMES = 16,
	localparam int NUM_INPUTS = NUM_LINES * MUX_LINES,
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2
) (
	input  logic                 pll_clk,
	input  logic                 reset,
	input  logic [NUM_LINES-1:0] line_in,
	input  logic                 enable,
	output logic [MUX_LINES-1:0] mux_out,
	output logic                 sh_reset,
	output logic                 integration_pulse,
	output logic                 result_valid,
	output pair_index_t          result_pair,
	output count_t               result_count
);

	// Full frame, valid while frame_strobe is high.
	logic [NUM_INPUTS-1:0] frame_bits;
	logic frame_strobe;
	// Frame strobe with disabled frames removed.
	logic count_strobe;
	// All pair counts, pair 0 lowest.
	count_t [NUM_PAIRS-1:0] pair_counts;

	// ----------------------------------------------------------
	// Scan and window timing.
	// ----------------------------------------------------------

	line_scanner #(.NUM_LINES(NUM_LINES), .MUX_LINES(MUX_LINES)) scanner_block (
		.pll_clk(pll_clk),
		.reset(reset),
		.line_in(line_in),
		.mux_out(mux_out),
		.sh_reset(sh_reset),
		.frame_bits(frame_bits),
		.frame_strobe(frame_strobe)
	);

	// Window end leaves the chip as integration_pulse.
	integration_timer #(.INTEG_FRAMES(INTEG_FRAMES)) timer_block (
		.pll_clk(pll_clk),
		.reset(reset),
		.frame_strobe(frame_strobe),
		.enable(enable),
		.count_strobe(count_strobe),
		.integ_end(integration_pulse)
	);

	// ----------------------------------------------------------
	// Pair array, i outer and j inner.
	// ----------------------------------------------------------

	for (genvar i = 0; i < NUM_INPUTS - 1; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_col
			// Rows before i, then offset within row i.
			localparam int P = i * NUM_INPUTS - (i * (i + 1)) / 2 + (j - i - 1);

			pair_correlator pair_block (
				.pll_clk(pll_clk),
				.reset(reset),
				.count_strobe(count_strobe),
				.integ_end(integration_pulse),
				.a(frame_bits[i]),
				.b(frame_bits[j]),
				.count(pair_counts[P])
			);
		end
	end

	// Drains the counts after each window.
	count_readout #(.NUM_LINES(NUM_LINES), .MUX_LINES(MUX_LINES)) readout_block (
		.pll_clk(pll_clk),
		.reset(reset),
		.integ_end(integration_pulse),
		.counts(pair_counts),
		.result_valid(result_valid),
		.result_pair(result_pair),
		.result_count(result_count)
	);

	// Frame must fit the bit index type.
	a_inputs_range: assert property (@(posedge pll_clk)
		NUM_INPUTS >= 2 && NUM_INPUTS <= MAX_INPUTS);

	// Shortest window must outlast one readout burst.
	a_window_len: assert property (@(posedge pll_clk)
		2 * INTEG_FRAMES > NUM_PAIRS);

endmodule

// File: count_readout.sv
`timescale 1ns/10ps

module count_readout
	import xc_count_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MUX_LINES = 2,
	localparam int NUM_INPUTS = NUM_LINES * MUX_LINES,
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2
) (
	input  logic                   pll_clk,
	input  logic                   reset,
	input  logic                   integ_end,
	input  count_t [NUM_PAIRS-1:0] counts,
	output logic                   result_valid,
	output pair_index_t            result_pair,
	output count_t                 result_count
);

	// Copy of the closing window, pair 0 in the low slot.
	count_t [NUM_PAIRS-1:0] snap;
	// Pair now on the outputs.
	pair_index_t rd_ptr;

	// ----------------------------------------------------------
	// Burst control.
	// ----------------------------------------------------------

	// Window end starts a burst of NUM_PAIRS strobes.
	// First strobe comes the cycle after integ_end.
	always_ff @(posedge pll_clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			rd_ptr <= '0;
		end else if (integ_end) begin
			result_valid <= 1'b1;
			rd_ptr <= '0;
		end else if (result_valid) begin
			if (rd_ptr == pair_index_t'(NUM_PAIRS - 1)) begin
				// Last pair out.
				result_valid <= 1'b0;
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Snapshot store.
	// ----------------------------------------------------------

	// Latched on the same edge that clears the correlators.
	// Shifted down one pair per strobe after that.
	always_ff @(posedge pll_clk) begin
		if (integ_end) begin
			snap <= counts;
		end else if (result_valid) begin
			snap <= snap >> $bits(count_t);
		end
	end

	// Current pair sits in the low slot.
	assign result_pair = rd_ptr;
	assign result_count = snap[0];

	// ----------------------------------------------------------
	// Checks.
	// ----------------------------------------------------------

	// No back-pressure, so a burst must end before the next window.
	a_no_overlap: assert property (@(posedge pll_clk) disable iff (reset)
		integ_end |-> !result_valid);

	// Every pair needs its own number.
	a_pair_range: assert property (@(posedge pll_clk)
		NUM_PAIRS >= 1 && NUM_PAIRS <= 2 ** $bits(pair_index_t));

endmodule

// File: pair_correlator.sv
`timescale 1ns/10ps

module pair_correlator
	import xc_count_pkg::*;
(
	input  logic   pll_clk,
	input  logic   reset,
	input  logic   count_strobe,
	input  logic   integ_end,
	input  logic   a,
	input  logic   b,
	output count_t count
);

	// Both inputs high in a counted frame.
	logic hit;

	// ----------------------------------------------------------
	// Zero-lag coincidence.
	// ----------------------------------------------------------

	// Only frames passed by the timer take part.
	assign hit = count_strobe & a & b;

	// ----------------------------------------------------------
	// Window accumulator.
	// ----------------------------------------------------------

	// Cleared on window end, once the readout has its copy.
	// Bounded by the window length, so no saturation.
	always_ff @(posedge pll_clk) begin
		if (reset) begin
			count <= '0;
		end else if (integ_end) begin
			count <= '0;
		end else if (hit) begin
			count <= count + 1'b1;
		end
	end

	// Only the window end may lower the count.
	// A wrap past the top would show up here.
	a_count_monotonic: assert property (@(posedge pll_clk) disable iff (reset)
		!integ_end |=> count >= $past(count));

endmodule

// File: integration_timer.sv
`timescale 1ns/10ps

module integration_timer
	import xc_count_pkg::*;
#(
	parameter int INTEG_FRAMES = 16
) (
	input  logic pll_clk,
	input  logic reset,
	input  logic frame_strobe,
	input  logic enable,
	output logic count_strobe,
	output logic integ_end
);

	// Counted frames in the open window.
	frame_count_t frame_cnt;

	// ----------------------------------------------------------
	// Frame gating.
	// ----------------------------------------------------------

	// Frames ending with enable low are dropped here.
	// The correlators never see them either.
	assign count_strobe = frame_strobe & enable;

	// ----------------------------------------------------------
	// Window counter.
	// ----------------------------------------------------------

	// Wraps on the last frame of a window.
	// The end pulse follows one cycle later.
	always_ff @(posedge pll_clk) begin
		if (reset) begin
			frame_cnt <= '0;
			integ_end <= 1'b0;
		end else begin
			integ_end <= 1'b0;
			if (count_strobe) begin
				if (frame_cnt == frame_count_t'(INTEG_FRAMES - 1)) begin
					frame_cnt <= '0;
					integ_end <= 1'b1;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
		end
	end

	// Window length must fit the frame counter.
	a_frames_range: assert property (@(posedge pll_clk)
		INTEG_FRAMES >= 1 && INTEG_FRAMES < 2 ** $bits(frame_count_t));

	// A frame is at least two cycles, so the clear never meets a count.
	a_end_no_strobe: assert property (@(posedge pll_clk) disable iff (reset)
		integ_end |-> !count_strobe);

endmodule

// File: line_scanner.sv
`timescale 1ns/10ps

module line_scanner
	import xc_line_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MUX_LINES = 2,
	localparam int NUM_INPUTS = NUM_LINES * MUX_LINES
) (
	input  logic                  pll_clk,
	input  logic                  reset,
	input  logic [NUM_LINES-1:0]  line_in,
	output logic [MUX_LINES-1:0]  mux_out,
	output logic                  sh_reset,
	output logic [NUM_INPUTS-1:0] frame_bits,
	output logic                  frame_strobe
);

	// Position in the scan, MUX_LINES is the hold-release slot.
	mux_index_t scan_idx;
	// Group that mux_out selects in the current cycle.
	mux_index_t cur_grp;
	// One-hot select for the slot in scan_idx.
	logic [MUX_LINES-1:0] next_sel;
	// First frame bit of the current group.
	input_index_t cap_base;
	// Line inputs widened to the frame.
	logic [NUM_INPUTS-1:0] line_wide;
	// Ones over one group, bit 0 upward.
	logic [NUM_INPUTS-1:0] group_mask;

	// ----------------------------------------------------------
	// Select decode.
	// ----------------------------------------------------------

	// Decode the slot index to a one-hot select.
	// The hold-release slot decodes to zero.
	always_comb begin
		next_sel = '0;
		for (int k = 0; k < MUX_LINES; k++) begin
			if (scan_idx == mux_index_t'(k)) begin
				next_sel[k] = 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Scan sequence.
	// ----------------------------------------------------------

	// One group per clock, then one hold-release clock.
	always_ff @(posedge pll_clk) begin
		if (reset) begin
			scan_idx <= '0;
			cur_grp <= '0;
			mux_out <= '0;
			sh_reset <= 1'b0;
		end else begin
			cur_grp <= scan_idx;
			mux_out <= next_sel;
			if (scan_idx == mux_index_t'(MUX_LINES)) begin
				// Frame complete, release the holds.
				scan_idx <= '0;
				sh_reset <= 1'b1;
			end else begin
				scan_idx <= scan_idx + 1'b1;
				sh_reset <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------
	// Frame capture.
	// ----------------------------------------------------------

	assign cap_base = input_index_t'(cur_grp * NUM_LINES);
	assign line_wide = NUM_INPUTS'(line_in);
	assign group_mask = NUM_INPUTS'({NUM_LINES{1'b1}});

	// Lines sampled at the end of a select cycle land in that group.
	always_ff @(posedge pll_clk) begin
		if (mux_out != '0) begin
			frame_bits <= (frame_bits & ~(group_mask << cap_base)) | (line_wide << cap_base);
		end
	end

	// Last group was stored at the edge opening this cycle.
	assign frame_strobe = sh_reset;

	// The external holds never see two groups at once.
	a_mux_onehot: assert property (@(posedge pll_clk) disable iff (reset)
		$onehot0(mux_out));

	// The slot counter must reach MUX_LINES without wrapping.
	a_mux_lines: assert property (@(posedge pll_clk)
		MUX_LINES >= 1 && MUX_LINES <= MAX_MUX_LINES);

endmodule

// File: xc_count_pkg.sv
package xc_count_pkg;

	// ----------------------------------------------------------
	// Coincidence counts, pair numbering and frame windows.
	// ----------------------------------------------------------

	// Width of one coincidence count.
	localparam int COUNT_W = 16;

	// Width of a pair number.
	localparam int PAIR_INDEX_W = 10;

	// Width of the frame counter within a window.
	localparam int FRAME_COUNT_W = 16;

	// One pair count, never above the window length.
	typedef logic [COUNT_W-1:0] count_t;

	// Pair number, (i,j) with i<j, i outer and j inner.
	typedef logic [PAIR_INDEX_W-1:0] pair_index_t;

	// Frames seen so far in the current window.
	typedef logic [FRAME_COUNT_W-1:0] frame_count_t;

endpackage

// File: xc_line_pkg.sv
package xc_line_pkg;

	// ----------------------------------------------------------
	// Input line and multiplexer scan description.
	// ----------------------------------------------------------

	// Width of the group index.
	localparam int MUX_INDEX_W = 4;

	// Width of a bit index within one frame.
	localparam int INPUT_INDEX_W = 5;

	// Index of the group now on the multiplexer.
	typedef logic [MUX_INDEX_W-1:0] mux_index_t;

	// Frame bit index, group times lines plus line.
	typedef logic [INPUT_INDEX_W-1:0] input_index_t;

	// Largest group count the index type can step through.
	// The counter also needs one extra value for the hold-release cycle.
	localparam int MAX_MUX_LINES = (2 ** MUX_INDEX_W) - 1;

	// Largest frame size, lines times groups.
	localparam int MAX_INPUTS = 2 ** INPUT_INDEX_W;

endpackage
